// File: tb.f
+incdir+src
src/hid_pkg.sv
src/report_capture.sv
src/device_classifier.sv
src/boot_report_decoder.sv
src/gamepad_decoder.sv
src/hid_report_host.sv
tb/tb_hid_report_host.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f tb.f \
    --top-module tb_hid_report_host -o sim_hid_report_host \
    && ./obj_dir/sim_hid_report_host > sim.log 2>&1 \
    || echo "build or simulation failed" >> sim.log
grep -q "All tests passed" sim.log && echo "PASS" \
    || { echo "FAIL, see sim.log"; exit 1; }

// File: tb/tb_hid_report_host.sv
//********************
// Testbench for the HID report host. Classifies devices
// through descriptor saves, then sends LFSR frames as a
// keyboard, a mouse and a gamepad and checks every output
// against a model kept here
//********************
`timescale 1ns/10ps
`default_nettype none
`include "hid_config.svh"

module tb_hid_report_host;
    import hid_pkg::*;

    localparam int RPT_TIMEOUT = 20;    // cycles to wait for report

    logic               usbclk;
    logic               usbrst_n;
    logic               frame;
    logic               byte_stb;
    hid_byte_t          byte_data;
    logic               save;
    logic [3:0]         save_reg;
    logic [3:0]         save_byte;
    logic               connected;
    dev_type_t          dev_type;
    logic               report;
    hid_byte_t          key_modifiers;
    hid_byte_t          key1;
    hid_byte_t          key2;
    hid_byte_t          key3;
    hid_byte_t          key4;
    hid_byte_t          mouse_btn;
    logic signed [7:0]  mouse_dx;
    logic signed [7:0]  mouse_dy;
    logic               game_l;
    logic               game_r;
    logic               game_u;
    logic               game_d;
    logic               game_a;
    logic               game_b;
    logic               game_x;
    logic               game_y;
    logic               game_sel;
    logic               game_sta;
    report_buf_t        last_report;

    // model state
    dev_type_t          m_dev;
    hid_byte_t          m_mod;
    hid_byte_t          m_keys [4];
    hid_byte_t          m_btn;
    logic signed [7:0]  m_dx;
    logic signed [7:0]  m_dy;
    logic [9:0]         m_game;     // l r u d a b x y sel sta
    logic               m_valid;
    hid_byte_t          m_lr [8];
    hid_byte_t          m_slots [`HID_DESC_SLOTS];
    logic               lr_known;   // all buffer bytes written once

    hid_byte_t          fb [8];     // frame being sent
    logic [31:0]        lfsr;
    int                 errors;
    int                 checks;

    hid_report_host i_dut (.*);

    initial begin
        usbclk = 1'b0;
        forever #10 usbclk = ~usbclk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    function automatic dev_type_t classify(input hid_byte_t cls, input hid_byte_t sub,
                                           input hid_byte_t proto);
        if (cls != 8'(`HID_CLASS_HID))
            return DEV_NONE;
        if (sub != 8'(`HID_SUBCLASS_BOOT))
            return DEV_GAMEPAD;
        return (proto == 8'(`HID_PROTOCOL_KEYBOARD)) ? DEV_KEYBOARD : DEV_MOUSE;
    endfunction

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_all();
        logic [63:0] lr;
        for (int k = 0; k < 8; k++)
            lr[8*k +: 8] = m_lr[k];
        compare("dev_type", dev_type, m_dev);
        compare("key_modifiers", key_modifiers, m_mod);
        compare("key1", key1, m_keys[0]);
        compare("key2", key2, m_keys[1]);
        compare("key3", key3, m_keys[2]);
        compare("key4", key4, m_keys[3]);
        compare("mouse_btn", mouse_btn, m_btn);
        compare("mouse_dx", $unsigned(mouse_dx), $unsigned(m_dx));
        compare("mouse_dy", $unsigned(mouse_dy), $unsigned(m_dy));
        compare("game", {game_l, game_r, game_u, game_d, game_a, game_b, game_x, game_y,
                         game_sel, game_sta}, m_game);
        if (lr_known)
            compare("last_report", last_report, lr);
    endtask

    task automatic model_pad(input int pos, input hid_byte_t b);
        case (pos)
            0: begin
                m_valid = (b[1:0] != `HID_ADAPTER_SKIP);
                if (m_valid)
                    m_game[9:6] = 4'b0000;
                if (b == 8'h00) m_game[9:8] = 2'b10;
                if (b == 8'hff) m_game[9:8] = 2'b01;
            end
            1: begin
                if (b == 8'h00) m_game[7:6] = 2'b10;
                if (b == 8'hff) m_game[7:6] = 2'b01;
            end
            3, 4: if (m_valid) begin
                // stick x moves l/r, stick y moves u/d
                if (b[7:6] == 2'b00) m_game[(pos == 3) ? 9 : 7 -: 2] = 2'b10;
                if (b[7:6] == 2'b11) m_game[(pos == 3) ? 9 : 7 -: 2] = 2'b01;
            end
            5: if (m_valid)
                m_game[5:2] = {b[5], b[6], b[4], b[7]};     // a b x y
            6: if (m_valid)
                m_game[1:0] = {b[4], b[5]};
            default: ;
        endcase
    endtask

    task automatic model_byte(input int pos, input hid_byte_t b);
        m_lr[pos] = b;
        if (m_dev == DEV_KEYBOARD) begin
            if (pos == 0)
                m_mod = b;
            else if (pos >= 2 && pos <= 5)
                m_keys[pos-2] = b;
        end else if (m_dev == DEV_MOUSE) begin
            if (pos == 0) m_btn = b;
            if (pos == 1) m_dx = b;
            if (pos == 2) m_dy = b;
        end else if (m_dev == DEV_GAMEPAD) begin
            model_pad(pos, b);
        end
    endtask

    task automatic send_frame(input int n, input logic expect_rpt);
        int   w;
        int   cnt;
        logic seen;
        @(posedge usbclk);
        frame <= 1'b1;
        for (int i = 0; i < n; i++) begin
            w = rand_bits(2) % 3 + 1;       // strobe lasts 1 to 3 cycles
            @(posedge usbclk);
            byte_data <= fb[i];
            byte_stb  <= 1'b1;
            repeat (w) @(posedge usbclk);
            byte_stb <= 1'b0;
            model_byte(i, fb[i]);
        end
        @(posedge usbclk);
        frame <= 1'b0;
        seen = 1'b0;
        for (cnt = 0; cnt < RPT_TIMEOUT && !seen; cnt++) begin
            @(negedge usbclk);
            seen = report;
        end
        if (expect_rpt && !seen) begin
            errors++;
            $display("no report pulse within %0d cycles after the frame ended", RPT_TIMEOUT);
        end else if (!expect_rpt && seen) begin
            errors++;
            $display("report pulse at %0t although no device type is set", $time);
        end
        if (seen) begin
            compare("mouse_dx", $unsigned(mouse_dx), $unsigned(m_dx));   // still held
            compare("mouse_dy", $unsigned(mouse_dy), $unsigned(m_dy));
            m_dx = '0;
            m_dy = '0;
            @(negedge usbclk);
        end
        check_all();
    endtask

    task automatic save_slot(input int slot, input int pos);
        int w;
        w = rand_bits(1) + 1;
        @(posedge usbclk);
        save      <= 1'b1;
        save_reg  <= 4'(slot);
        save_byte <= 4'(pos);
        repeat (w) @(posedge usbclk);
        save <= 1'b0;
        repeat (2) @(posedge usbclk);      // save_reg held through the fall
        m_slots[slot] = m_lr[pos];
        if (slot == `HID_SLOT_PROTOCOL)
            m_dev = classify(m_slots[`HID_SLOT_CLASS], m_slots[`HID_SLOT_SUBCLASS],
                             m_slots[`HID_SLOT_PROTOCOL]);
    endtask

    // codes sit at bytes 7, 3 and 6 of an 8 byte frame
    task automatic load_descriptor(input hid_byte_t cls, input hid_byte_t sub,
                                   input hid_byte_t proto);
        for (int i = 0; i < 8; i++)
            fb[i] = 8'(rand_bits(8));
        fb[7] = cls;
        fb[3] = sub;
        fb[6] = proto;
        lr_known = 1'b1;
        send_frame(8, m_dev != DEV_NONE);
        save_slot(`HID_SLOT_CLASS, 7);
        save_slot(`HID_SLOT_SUBCLASS, 3);
        save_slot(`HID_SLOT_PROTOCOL, 6);
        @(negedge usbclk);
        compare("dev_type", dev_type, m_dev);
    endtask

    task automatic random_frame();
        int n;
        n = rand_bits(3) % 6 + 3;
        for (int i = 0; i < 8; i++)
            fb[i] = 8'(rand_bits(8));
        case (rand_bits(2))
            2'd0: fb[0] = 8'h00;
            2'd1: fb[0] = 8'hff;
            2'd2: fb[0] = {6'(rand_bits(6)), `HID_ADAPTER_SKIP};   // adapter record
            default: ;
        endcase
        if (rand_bits(1))
            fb[1] = rand_bits(1) ? 8'h00 : 8'hff;
        send_frame(n, m_dev != DEV_NONE);
    endtask

    initial begin
        hid_byte_t cls;
        hid_byte_t sub;
        hid_byte_t proto;
        lfsr      = 32'hb13e;
        errors    = 0;
        checks    = 0;
        m_dev     = DEV_NONE;
        m_mod     = '0;
        m_keys    = '{default: '0};
        m_btn     = '0;
        m_dx      = '0;
        m_dy      = '0;
        m_game    = '0;
        m_valid   = 1'b0;
        lr_known  = 1'b0;
        usbrst_n  = 1'b0;
        frame     = 1'b0;
        byte_stb  = 1'b0;
        byte_data = '0;
        save      = 1'b0;
        save_reg  = '0;
        save_byte = '0;
        connected = 1'b1;
        repeat (5) @(posedge usbclk);
        usbrst_n <= 1'b1;
        @(negedge usbclk);
        check_all();

        // classification with mixed random and chosen codes
        for (int r = 0; r < 8; r++) begin
            cls   = rand_bits(1) ? 8'(`HID_CLASS_HID) : 8'(rand_bits(8));
            sub   = rand_bits(1) ? 8'(`HID_SUBCLASS_BOOT) : 8'(rand_bits(8));
            proto = rand_bits(1) ? 8'(`HID_PROTOCOL_KEYBOARD) : 8'(rand_bits(8));
            load_descriptor(cls, sub, proto);
        end

        load_descriptor(8'd3, 8'd1, 8'd1);     // keyboard
        repeat (8) random_frame();
        load_descriptor(8'd3, 8'd1, 8'd2);     // mouse
        repeat (8) random_frame();
        load_descriptor(8'd3, 8'd0, 8'd0);     // gamepad
        repeat (16) random_frame();

        // unplug, then a frame must not report
        @(posedge usbclk);
        connected <= 1'b0;
        repeat (2) @(negedge usbclk);
        m_dev = DEV_NONE;
        compare("dev_type", dev_type, m_dev);
        random_frame();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/hid_report_host.sv
//********************
// Top of the HID report host. Feed it the receive engine's
// frame, byte and save signals; it gives the device type,
// decoded fields and a report pulse per finished report
//********************
`timescale 1ns/10ps
`default_nettype none

module hid_report_host (
    input  wire                  usbclk,
    input  wire                  usbrst_n,
    input  wire                  frame,
    input  wire                  byte_stb,
    input  wire hid_pkg::hid_byte_t byte_data,
    input  wire                  save,
    input  wire [3:0]            save_reg,
    input  wire [3:0]            save_byte,
    input  wire                  connected,
    output wire hid_pkg::dev_type_t dev_type,
    output wire                  report,
    output wire hid_pkg::hid_byte_t key_modifiers,
    output wire hid_pkg::hid_byte_t key1,
    output wire hid_pkg::hid_byte_t key2,
    output wire hid_pkg::hid_byte_t key3,
    output wire hid_pkg::hid_byte_t key4,
    output wire hid_pkg::hid_byte_t mouse_btn,
    output wire signed [7:0]     mouse_dx,
    output wire signed [7:0]     mouse_dy,
    output wire                  game_l,
    output wire                  game_r,
    output wire                  game_u,
    output wire                  game_d,
    output wire                  game_a,
    output wire                  game_b,
    output wire                  game_x,
    output wire                  game_y,
    output wire                  game_sel,
    output wire                  game_sta,
    output wire hid_pkg::report_buf_t last_report
);
    import hid_pkg::*;

    wire            byte_valid;
    wire byte_idx_t byte_idx;
    wire hid_byte_t byte_val;

    report_capture i_capture (
        .usbclk      (usbclk),
        .usbrst_n    (usbrst_n),
        .frame       (frame),
        .byte_stb    (byte_stb),
        .byte_data   (byte_data),
        .dev_type    (dev_type),
        .byte_valid  (byte_valid),
        .byte_idx    (byte_idx),
        .byte_val    (byte_val),
        .last_report (last_report),
        .report      (report)
    );

    device_classifier i_classifier (
        .usbclk      (usbclk),
        .usbrst_n    (usbrst_n),
        .save        (save),
        .save_reg    (save_reg),
        .save_byte   (save_byte),
        .last_report (last_report),    // saves pick bytes of the stored report
        .connected   (connected),
        .dev_type    (dev_type)
    );

    boot_report_decoder i_boot (
        .usbclk        (usbclk),
        .usbrst_n      (usbrst_n),
        .byte_valid    (byte_valid),
        .byte_idx      (byte_idx),
        .byte_val      (byte_val),
        .dev_type      (dev_type),
        .report        (report),
        .key_modifiers (key_modifiers),
        .key1          (key1),
        .key2          (key2),
        .key3          (key3),
        .key4          (key4),
        .mouse_btn     (mouse_btn),
        .mouse_dx      (mouse_dx),
        .mouse_dy      (mouse_dy)
    );

    gamepad_decoder i_gamepad (
        .usbclk     (usbclk),
        .usbrst_n   (usbrst_n),
        .byte_valid (byte_valid),
        .byte_idx   (byte_idx),
        .byte_val   (byte_val),
        .dev_type   (dev_type),
        .game_l     (game_l),
        .game_r     (game_r),
        .game_u     (game_u),
        .game_d     (game_d),
        .game_a     (game_a),
        .game_b     (game_b),
        .game_x     (game_x),
        .game_y     (game_y),
        .game_sel   (game_sel),
        .game_sta   (game_sta)
    );

endmodule

`default_nettype wire

// File: src/gamepad_decoder.sv
//********************
// Generic gamepad decoder. Directions come from bytes 0/1 or
// from the stick bytes, buttons from bytes 5 and 6. Records
// of a dual controller adapter marked by byte 0 are skipped
//********************
`timescale 1ns/10ps
`default_nettype none
`include "hid_config.svh"

module gamepad_decoder (
    input  wire                  usbclk,
    input  wire                  usbrst_n,
    input  wire                  byte_valid,
    input  wire hid_pkg::byte_idx_t byte_idx,
    input  wire hid_pkg::hid_byte_t byte_val,
    input  wire hid_pkg::dev_type_t dev_type,
    output logic                 game_l,
    output logic                 game_r,
    output logic                 game_u,
    output logic                 game_d,
    output logic                 game_a,
    output logic                 game_b,
    output logic                 game_x,
    output logic                 game_y,
    output logic                 game_sel,
    output logic                 game_sta
);
    import hid_pkg::*;

    localparam byte_idx_t STICK_X = byte_idx_t'(`HID_PAD_STICK);
    localparam byte_idx_t STICK_Y = byte_idx_t'(`HID_PAD_STICK + 1);
    localparam byte_idx_t BTN_FACE = byte_idx_t'(`HID_PAD_BUTTONS);
    localparam byte_idx_t BTN_SYS = byte_idx_t'(`HID_PAD_BUTTONS + 1);

    logic valid;    // current record applies

    always_ff @(posedge usbclk) begin
        if (!usbrst_n) begin
            valid    <= 1'b0;
            game_l   <= 1'b0;
            game_r   <= 1'b0;
            game_u   <= 1'b0;
            game_d   <= 1'b0;
            game_a   <= 1'b0;
            game_b   <= 1'b0;
            game_x   <= 1'b0;
            game_y   <= 1'b0;
            game_sel <= 1'b0;
            game_sta <= 1'b0;
        end else if (byte_valid && dev_type == DEV_GAMEPAD) begin
            case (byte_idx)
                4'd0: begin
                    valid <= (byte_val[1:0] != `HID_ADAPTER_SKIP);
                    if (byte_val[1:0] != `HID_ADAPTER_SKIP)
                        {game_l, game_r, game_u, game_d} <= 4'b0000;
                    // some pads report x here, even on a skipped record
                    if (byte_val == 8'h00) {game_l, game_r} <= 2'b10;
                    if (byte_val == 8'hff) {game_l, game_r} <= 2'b01;
                end
                4'd1: begin
                    if (byte_val == 8'h00) {game_u, game_d} <= 2'b10;
                    if (byte_val == 8'hff) {game_u, game_d} <= 2'b01;
                end
                STICK_X: if (valid) begin
                    if (byte_val[7:6] == 2'b00) {game_l, game_r} <= 2'b10;
                    if (byte_val[7:6] == 2'b11) {game_l, game_r} <= 2'b01;
                end
                STICK_Y: if (valid) begin
                    if (byte_val[7:6] == 2'b00) {game_u, game_d} <= 2'b10;
                    if (byte_val[7:6] == 2'b11) {game_u, game_d} <= 2'b01;
                end
                BTN_FACE: if (valid) begin
                    {game_y, game_b, game_a, game_x} <= byte_val[7:4];
                end
                BTN_SYS: if (valid) begin
                    {game_sta, game_sel} <= byte_val[5:4];
                end
                default: ;
            endcase
        end
    end

    a_lr_exclusive: assert property (@(posedge usbclk) disable iff (!usbrst_n)
        !(game_l && game_r));

endmodule

`default_nettype wire

// File: src/boot_report_decoder.sv
//********************
// Boot protocol decoder for keyboards and mice. Fields are
// taken from the byte stream as it arrives; mouse motion is
// cleared after each report pulse
//********************
`timescale 1ns/10ps
`default_nettype none
`include "hid_config.svh"

module boot_report_decoder (
    input  wire                  usbclk,
    input  wire                  usbrst_n,
    input  wire                  byte_valid,
    input  wire hid_pkg::byte_idx_t byte_idx,
    input  wire hid_pkg::hid_byte_t byte_val,
    input  wire hid_pkg::dev_type_t dev_type,
    input  wire                  report,
    output hid_pkg::hid_byte_t   key_modifiers,
    output hid_pkg::hid_byte_t   key1,
    output hid_pkg::hid_byte_t   key2,
    output hid_pkg::hid_byte_t   key3,
    output hid_pkg::hid_byte_t   key4,
    output hid_pkg::hid_byte_t   mouse_btn,
    output logic signed [7:0]    mouse_dx,
    output logic signed [7:0]    mouse_dy
);
    import hid_pkg::*;

    localparam byte_idx_t KEY1_POS = byte_idx_t'(`HID_KEY_FIRST);
    localparam byte_idx_t KEY2_POS = byte_idx_t'(`HID_KEY_FIRST + 1);
    localparam byte_idx_t KEY3_POS = byte_idx_t'(`HID_KEY_FIRST + 2);
    localparam byte_idx_t KEY4_POS = byte_idx_t'(`HID_KEY_FIRST + 3);

    always_ff @(posedge usbclk) begin
        if (!usbrst_n) begin
            key_modifiers <= '0;
            key1          <= '0;
            key2          <= '0;
            key3          <= '0;
            key4          <= '0;
            mouse_btn     <= '0;
            mouse_dx      <= '0;
            mouse_dy      <= '0;
        end else begin
            if (report) begin           // motion is relative, drop it once reported
                mouse_dx <= '0;
                mouse_dy <= '0;
            end
            if (byte_valid && dev_type == DEV_KEYBOARD) begin
                case (byte_idx)
                    4'd0:     key_modifiers <= byte_val;
                    KEY1_POS: key1 <= byte_val;   // byte 1 is reserved
                    KEY2_POS: key2 <= byte_val;
                    KEY3_POS: key3 <= byte_val;
                    KEY4_POS: key4 <= byte_val;
                    default: ;
                endcase
            end
            if (byte_valid && dev_type == DEV_MOUSE) begin
                case (byte_idx)
                    4'd0: mouse_btn <= byte_val;    // middle, right, left in low bits
                    4'd1: mouse_dx  <= byte_val;
                    4'd2: mouse_dy  <= byte_val;
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: src/device_classifier.sv
//********************
// Keeps the descriptor bytes that the receive engine asks
// to save and works out the device type when the protocol
// byte has been stored. Disconnect clears the type
//********************
`timescale 1ns/10ps
`default_nettype none
`include "hid_config.svh"

module device_classifier (
    input  wire                  usbclk,
    input  wire                  usbrst_n,
    input  wire                  save,
    input  wire [3:0]            save_reg,
    input  wire [3:0]            save_byte,
    input  wire hid_pkg::report_buf_t last_report,
    input  wire                  connected,
    output hid_pkg::dev_type_t   dev_type
);
    import hid_pkg::*;

    hid_byte_t slots [`HID_DESC_SLOTS];
    logic      save_d;
    logic      connected_d;

    always_ff @(posedge usbclk) begin
        if (save && (save_reg[2:0] < 3'(`HID_DESC_SLOTS)))
            slots[save_reg[2:0]] <= last_report[8*save_byte[2:0] +: 8];
    end

    always_ff @(posedge usbclk) begin
        if (!usbrst_n) begin
            save_d      <= 1'b0;
            connected_d <= 1'b0;
            dev_type    <= DEV_NONE;
        end else begin
            save_d      <= save;
            connected_d <= connected;
            // save of the protocol slot just ended
            if (!save && save_d && save_reg == 4'(`HID_SLOT_PROTOCOL)) begin
                if (slots[`HID_SLOT_CLASS] != 8'(`HID_CLASS_HID))
                    dev_type <= DEV_NONE;
                else if (slots[`HID_SLOT_SUBCLASS] != 8'(`HID_SUBCLASS_BOOT))
                    dev_type <= DEV_GAMEPAD;        // non-boot hid
                else if (slots[`HID_SLOT_PROTOCOL] == 8'(`HID_PROTOCOL_KEYBOARD))
                    dev_type <= DEV_KEYBOARD;
                else
                    dev_type <= DEV_MOUSE;
            end
            if (!connected && connected_d)
                dev_type <= DEV_NONE;               // unplug wins
        end
    end

    a_disconnect: assert property (@(posedge usbclk) disable iff (!usbrst_n)
        $fell(connected) |=> (dev_type == DEV_NONE));

endmodule

`default_nettype wire

// File: src/report_capture.sv
//********************
// Front end of the report host. Samples the receive engine's
// frame and byte strobe, numbers the bytes of a frame, keeps
// the last report and pulses report when a frame ends
//********************
`timescale 1ns/10ps
`default_nettype none
`include "hid_config.svh"

module report_capture (
    input  wire                  usbclk,
    input  wire                  usbrst_n,
    input  wire                  frame,
    input  wire                  byte_stb,
    input  wire hid_pkg::hid_byte_t byte_data,
    input  wire hid_pkg::dev_type_t dev_type,
    output logic                 byte_valid,
    output hid_pkg::byte_idx_t   byte_idx,
    output hid_pkg::hid_byte_t   byte_val,
    output hid_pkg::report_buf_t last_report,
    output logic                 report
);
    import hid_pkg::*;

    localparam int POS_W = $clog2(`HID_REPORT_BYTES);

    logic             frame_r;
    logic             frame_d;
    logic             stb_r;
    logic             stb_d;
    hid_byte_t        data_r;
    logic [POS_W-1:0] pos;

    // engine strobe spans several cycles, only its rise counts
    assign byte_valid = frame_r & stb_r & ~stb_d;
    assign byte_val   = data_r;
    assign pos        = byte_idx[POS_W-1:0];   // wraps past the buffer end

    always_ff @(posedge usbclk) begin
        if (!usbrst_n) begin
            frame_r  <= 1'b0;
            frame_d  <= 1'b0;
            stb_r    <= 1'b0;
            stb_d    <= 1'b0;
            byte_idx <= '0;
            report   <= 1'b0;
        end else begin
            frame_r <= frame;
            frame_d <= frame_r;
            stb_r   <= byte_stb;
            stb_d   <= stb_r;
            report  <= ~frame_r & frame_d & (dev_type != DEV_NONE);
            if (!frame_r)
                byte_idx <= '0;
            else if (byte_valid)
                byte_idx <= byte_idx + 1'b1;
        end
    end

    always_ff @(posedge usbclk) begin
        data_r <= byte_data;
        if (byte_valid)
            last_report[8*pos +: 8] <= data_r;
    end

    // one pulse per frame end
    a_report_pulse: assert property (@(posedge usbclk) disable iff (!usbrst_n)
        report |=> !report);

endmodule

`default_nettype wire

// File: src/hid_pkg.sv
//********************
// Shared types of the report host: device type and the
// byte, position and report buffer types
//********************
`default_nettype none

package hid_pkg;

    `include "hid_config.svh"

    // device class as worked out from the interface descriptor
    typedef enum logic [1:0] {
        DEV_NONE     = 2'd0,
        DEV_KEYBOARD = 2'd1,
        DEV_MOUSE    = 2'd2,
        DEV_GAMEPAD  = 2'd3
    } dev_type_t;

    typedef logic [7:0] hid_byte_t;

    // byte n sits in bits 8n+7 down to 8n
    typedef logic [8*`HID_REPORT_BYTES-1:0] report_buf_t;

    typedef logic [3:0] byte_idx_t;     // position within a frame

endpackage

`default_nettype wire

// File: src/hid_config.svh
//********************
// Report host constants. Include wherever report sizes,
// descriptor slots or HID class codes are needed
//********************
`ifndef HID_CONFIG_SVH
`define HID_CONFIG_SVH

`define HID_REPORT_BYTES 8      // report bytes kept
`define HID_DESC_SLOTS 7        // vid l/h, pid l/h, class, subclass, protocol

`define HID_SLOT_CLASS 4
`define HID_SLOT_SUBCLASS 5
`define HID_SLOT_PROTOCOL 6

`define HID_CLASS_HID 3
`define HID_SUBCLASS_BOOT 1
`define HID_PROTOCOL_KEYBOARD 1

`define HID_KEY_FIRST 2         // keyboard key codes start here
`define HID_PAD_STICK 3         // gamepad x axis, y axis follows
`define HID_PAD_BUTTONS 5       // face buttons, system buttons follow
`define HID_ADAPTER_SKIP 2'b10  // byte 0 low bits of an ignored adapter record

`endif
